// File: Bender.yml
package:
  name: tiny16

sources:
  - files:
      - hw/tiny16_pkg.sv
      - hw/tiny16_decode.sv
      - hw/tiny16_video.sv
      - hw/tiny16_mem.sv
      - hw/tiny16_game.sv
  - target: test
    files:
      - tests/tiny16_tb.sv

// File: hw/tiny16_decode.sv
// Selects are combinational from the strobe; hold must stay high while rst is high
`timescale 1ns/1ns
`default_nettype none

module tiny16_decode (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 hold,
    input  tiny16_pkg::cpu_bus_t bus,
    output tiny16_pkg::sel_t     sel,
    output logic                 wr
);
    import tiny16_pkg::*;

    logic       active;
    logic [2:0] region;

    // Strobes are dropped while the main side is held
    assign active = bus.stb && !hold;
    assign region = bus.addr[11:9];

    always_comb begin
        sel      = '0;
        sel.char = active && (region == MAP_CHAR);
        sel.pal  = active && (region == MAP_PAL);
        sel.obj  = active && (region == MAP_OBJ);
        sel.ram  = active && (region == MAP_RAM);
        sel.xram = active && (region == MAP_XRAM);
    end

    // Write strobe for every region
    assign wr = active && !bus.rnw;

    // Map codes must stay distinct in the package
    a_sel_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(sel)
    ) else $error("more than one chip select active");

    // Held reset comes from the video line count at the top level
    a_hold_quiet: assert property (
        @(posedge clk) disable iff (rst)
        hold |-> (!wr && sel == '0)
    ) else $error("bus access while main side held");

    // Once released, the main side stays released until the next rst
    a_hold_stays: assert property (
        @(posedge clk) disable iff (rst)
        !hold |=> !hold
    ) else $error("held reset asserted again without rst");

endmodule

`default_nettype wire

// File: hw/tiny16_game.sv
// Main bus is ignored until vrender reaches RST_LINE after rst; cpu_din is valid one cycle after a read strobe
`timescale 1ns/1ns
`default_nettype none

module tiny16_game (
    input  logic                 clk,
    input  logic                 rst,
    input  tiny16_pkg::cpu_bus_t bus,
    input  logic [3:0]           tile_bank,
    input  logic [7:0]           st_addr,
    input  logic [15:0]          dipsw,
    input  logic                 char_ok,
    input  logic [15:0]          xram_data,
    input  logic                 xram_ok,
    output logic [15:0]          cpu_din,
    output logic                 ram_ok,
    output tiny16_pkg::vtiming_t timing,
    output tiny16_pkg::gfx_req_t char_req,
    output logic                 gfx_ok,
    output logic                 xram_cs,
    output logic                 xram_we,
    output logic [11:0]          xram_addr,
    output logic [7:0]           st_dout
);
    import tiny16_pkg::*;

    sel_t        sel;
    gfx_req_t    raw_req;
    logic        wr;
    logic        hold;
    logic        pal_rd_q;
    logic        ram_rd_q;
    logic [15:0] pal_dout;
    logic [15:0] ram_data;

    // Main side stays in reset until the video reaches RST_LINE
    always_ff @(posedge clk) begin
        if (rst) begin
            hold <= 1'b1;
        end else if (timing.vrender == 5'(RST_LINE)) begin
            hold <= 1'b0;
        end
    end

    // Read selects delayed to line up with registered RAM data
    always_ff @(posedge clk) begin
        if (rst) begin
            pal_rd_q <= 1'b0;
            ram_rd_q <= 1'b0;
        end else begin
            pal_rd_q <= sel.pal && bus.rnw;
            ram_rd_q <= sel.ram && bus.rnw;
        end
    end

    // xram data passes straight through while the access is held
    always_comb begin
        if (pal_rd_q) begin
            cpu_din = pal_dout;
        end else if (ram_rd_q || xram_cs) begin
            cpu_din = ram_data;
        end else begin
            cpu_din = '0;
        end
    end

    // Status readback
    always_ff @(posedge clk) begin
        case (st_addr[7:4])
            4'd0:    st_dout <= {timing.vrender, timing.vint, timing.lhbl, timing.lvbl};
            4'd1:    st_dout <= {4'd0, tile_bank};
            4'd3:    st_dout <= st_addr[0] ? dipsw[15:8] : dipsw[7:0];
            default: st_dout <= '0;
        endcase
    end

    tiny16_decode u_decode (
        .clk  ( clk  ),
        .rst  ( rst  ),
        .hold ( hold ),
        .bus  ( bus  ),
        .sel  ( sel  ),
        .wr   ( wr   )
    );

    tiny16_video u_video (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .bus      ( bus      ),
        .pal_sel  ( sel.pal  ),
        .wr       ( wr       ),
        .timing   ( timing   ),
        .pal_dout ( pal_dout ),
        .req      ( raw_req  )
    );

    tiny16_mem u_mem (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .bus       ( bus       ),
        .sel       ( sel       ),
        .wr        ( wr        ),
        .tile_bank ( tile_bank ),
        .req_in    ( raw_req   ),
        .char_ok   ( char_ok   ),
        .xram_data ( xram_data ),
        .xram_ok   ( xram_ok   ),
        .req_out   ( char_req  ),
        .gfx_ok    ( gfx_ok    ),
        .xram_cs   ( xram_cs   ),
        .xram_we   ( xram_we   ),
        .xram_addr ( xram_addr ),
        .ram_data  ( ram_data  ),
        .ram_ok    ( ram_ok    )
    );

endmodule

`default_nettype wire

// File: hw/tiny16_mem.sv
// External RAM strobes are combinational from the selects; the bus master must hold xram reads until ram_ok
`timescale 1ns/1ns
`default_nettype none

module tiny16_mem (
    input  logic                 clk,
    input  logic                 rst,
    input  tiny16_pkg::cpu_bus_t bus,
    input  tiny16_pkg::sel_t     sel,
    input  logic                 wr,
    input  logic [3:0]           tile_bank,
    input  tiny16_pkg::gfx_req_t req_in,
    input  logic                 char_ok,
    input  logic [15:0]          xram_data,
    input  logic                 xram_ok,
    output tiny16_pkg::gfx_req_t req_out,
    output logic                 gfx_ok,
    output logic                 xram_cs,
    output logic                 xram_we,
    output logic [11:0]          xram_addr,
    output logic [15:0]          ram_data,
    output logic                 ram_ok
);
    logic        wram_we;
    logic [7:0]  wram_addr;
    logic [15:0] wram_q;
    logic [15:0] wram [256];

    // Tile bank replaces the upper fetch bits
    always_ff @(posedge clk) begin
        if (rst) begin
            req_out.valid <= 1'b0;
        end else begin
            req_out.valid <= req_in.valid;
        end
        req_out.addr <= {tile_bank, req_in.addr[8:0]};
    end

    assign gfx_ok = req_out.valid && char_ok;

    // External RAM window
    assign xram_cs   = sel.xram;
    assign xram_we   = sel.xram && wr;
    assign xram_addr = bus.addr;

    // Work RAM, 256 words
    assign wram_we   = sel.ram && wr;
    assign wram_addr = bus.addr[7:0];

    always_ff @(posedge clk) begin
        if (wram_we) begin
            if (!bus.dsn[1]) begin
                wram[wram_addr][15:8] <= bus.data[15:8];
            end
            if (!bus.dsn[0]) begin
                wram[wram_addr][7:0] <= bus.data[7:0];
            end
        end
        if (sel.ram) begin
            wram_q <= wram[wram_addr];
        end
    end

    // Only external RAM can stall
    assign ram_ok   = !xram_cs || xram_ok;
    assign ram_data = xram_cs ? xram_data : wram_q;

    a_we_cs: assert property (
        @(posedge clk) disable iff (rst)
        xram_we |-> xram_cs
    ) else $error("xram_we without xram_cs");

    // Master keeps the access up until the RAM answers
    a_xram_held: assert property (
        @(posedge clk) disable iff (rst)
        (xram_cs && !xram_ok) |=> xram_cs
    ) else $error("xram access dropped before ram_ok");

endmodule

`default_nettype wire

// File: hw/tiny16_pkg.sv
// Geometry counts are in clocks, one pixel per clock; map codes decode the top 3 bits of a 12-bit word address
`default_nettype none

package tiny16_pkg;

    // Frame geometry
    localparam int H_TOTAL   = 64;
    localparam int V_TOTAL   = 32;
    localparam int H_VIS     = 48;
    localparam int V_VIS     = 24;

    // Interrupt line and main-side reset release line
    localparam int VINT_LINE = 24;
    localparam int RST_LINE  = 20;

    // Main bus regions, addr[11:9]
    localparam logic [2:0] MAP_CHAR = 3'd0;
    localparam logic [2:0] MAP_PAL  = 3'd1;
    localparam logic [2:0] MAP_OBJ  = 3'd2;
    localparam logic [2:0] MAP_RAM  = 3'd6;
    localparam logic [2:0] MAP_XRAM = 3'd7;

    // Main CPU access, dsn is active low per byte lane
    typedef struct packed {
        logic [11:0] addr;
        logic [15:0] data;
        logic [1:0]  dsn;
        logic        rnw;
        logic        stb;
    } cpu_bus_t;

    // Blanking levels are active low
    typedef struct packed {
        logic [5:0] hcnt;
        logic [4:0] vrender;
        logic       lhbl;
        logic       lvbl;
        logic       vint;
    } vtiming_t;

    typedef struct packed {
        logic [12:0] addr;
        logic        valid;
    } gfx_req_t;

    // One-hot chip selects
    typedef struct packed {
        logic char;
        logic pal;
        logic obj;
        logic ram;
        logic xram;
    } sel_t;

endpackage

`default_nettype wire

// File: hw/tiny16_video.sv
// No pixel output; the fetch request is built from the next position for a registered consumer
`timescale 1ns/1ns
`default_nettype none

module tiny16_video (
    input  logic                 clk,
    input  logic                 rst,
    input  tiny16_pkg::cpu_bus_t bus,
    input  logic                 pal_sel,
    input  logic                 wr,
    output tiny16_pkg::vtiming_t timing,
    output logic [15:0]          pal_dout,
    output tiny16_pkg::gfx_req_t req
);
    import tiny16_pkg::*;

    logic [5:0]  hcnt;
    logic [5:0]  hnext;
    logic [4:0]  vcnt;
    logic [4:0]  vnext;
    logic        line_end;
    logic        vint;
    logic        pal_we;
    logic [5:0]  pal_addr;
    logic [15:0] pal [64];

    assign line_end = (hcnt == 6'(H_TOTAL - 1));

    // Position after the coming edge
    always_comb begin
        hnext = line_end ? 6'd0 : hcnt + 6'd1;
        vnext = vcnt;
        if (line_end) begin
            vnext = (vcnt == 5'(V_TOTAL - 1)) ? 5'd0 : vcnt + 5'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
            vint <= 1'b0;
        end else begin
            hcnt <= hnext;
            vcnt <= vnext;
            // High for the first pixel of the interrupt line
            vint <= line_end && (vnext == 5'(VINT_LINE));
        end
    end

    assign timing.hcnt    = hcnt;
    assign timing.vrender = vcnt;
    assign timing.lhbl    = (hcnt < 6'(H_VIS));
    assign timing.lvbl    = (vcnt < 5'(V_VIS));
    assign timing.vint    = vint;

    // Palette of 64 words with byte lanes
    assign pal_we   = pal_sel && wr;
    assign pal_addr = bus.addr[5:0];

    // Cleared by rst so the main CPU sees a black palette
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 64; i++) begin
                pal[i] <= '0;
            end
        end else if (pal_we) begin
            if (!bus.dsn[1]) begin
                pal[pal_addr][15:8] <= bus.data[15:8];
            end
            if (!bus.dsn[0]) begin
                pal[pal_addr][7:0] <= bus.data[7:0];
            end
        end
    end

    // Read data one cycle after the strobe
    always_ff @(posedge clk) begin
        if (pal_sel) begin
            pal_dout <= pal[pal_addr];
        end
    end

    // Character fetch for the next pixel is registered downstream
    // Row in the upper bits, column per 8 pixels, then the line within the tile
    assign req.valid = (hnext < 6'(H_VIS)) && (vnext < 5'(V_VIS));
    assign req.addr  = {2'b00, vnext, hnext[5:3], vnext[2:0]};

    a_vint_pulse: assert property (
        @(posedge clk) disable iff (rst)
        timing.vint |=> !timing.vint
    ) else $error("vint longer than one cycle");

endmodule

`default_nettype wire

// File: tests/tiny16_tb.sv
// Inputs change on the falling edge; the model assumes one pixel per clock and a single reset
`timescale 1ns/1ns
`default_nettype none

module tiny16_tb;
    import tiny16_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RUN_FRAMES   = 4;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int WATCHDOG_NS  = (RUN_FRAMES + 2) * FRAME_CYCLES * CLK_PERIOD;

    logic        clk;
    logic        rst;
    cpu_bus_t    bus;
    logic [3:0]  tile_bank;
    logic [7:0]  st_addr;
    logic [15:0] dipsw;
    logic        char_ok;
    logic [15:0] xram_data;
    logic        xram_ok;
    logic [15:0] cpu_din;
    logic        ram_ok;
    vtiming_t    timing;
    gfx_req_t    char_req;
    logic        gfx_ok;
    logic        xram_cs;
    logic        xram_we;
    logic [11:0] xram_addr;
    logic [7:0]  st_dout;

    // Reference model with the frame position counted as a pixel index
    int          m_pos = 0;
    logic        m_vint = 1'b0;
    logic        m_hold = 1'b1;
    logic        m_req_valid = 1'b0;
    logic [3:0]  m_bank = '0;
    logic [7:0]  m_st = '0;
    logic        m_live = 1'b0;
    logic [15:0] pal_m [64];
    logic [15:0] wram_m [256];
    logic [7:0]  wram_known [$];

    logic [31:0] lcg_state = 32'd42154;
    int          vint_count = 0;
    int          frames_done = 0;

    tiny16_game DUT (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .bus       ( bus       ),
        .tile_bank ( tile_bank ),
        .st_addr   ( st_addr   ),
        .dipsw     ( dipsw     ),
        .char_ok   ( char_ok   ),
        .xram_data ( xram_data ),
        .xram_ok   ( xram_ok   ),
        .cpu_din   ( cpu_din   ),
        .ram_ok    ( ram_ok    ),
        .timing    ( timing    ),
        .char_req  ( char_req  ),
        .gfx_ok    ( gfx_ok    ),
        .xram_cs   ( xram_cs   ),
        .xram_we   ( xram_we   ),
        .xram_addr ( xram_addr ),
        .st_dout   ( st_dout   )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired after %0d ns before the test finished", WATCHDOG_NS);
    end

    function automatic logic [23:0] rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        // Low LCG bits repeat quickly
        return lcg_state[31:8];
    endfunction

    function automatic logic [5:0] h_of(input int pos);
        return 6'(pos % H_TOTAL);
    endfunction

    function automatic logic [4:0] v_of(input int pos);
        return 5'(pos / H_TOTAL);
    endfunction

    function automatic logic [15:0] merge_lanes(input logic [15:0] old,
                                                input logic [15:0] data,
                                                input logic [1:0]  dsn);
        logic [15:0] res;
        res = old;
        if (!dsn[1]) begin
            res[15:8] = data[15:8];
        end
        if (!dsn[0]) begin
            res[7:0] = data[7:0];
        end
        return res;
    endfunction

    // Favor the status pages that hold data
    function automatic logic [7:0] pick_status_addr(input logic [23:0] r);
        logic [3:0] page;
        case (r[1:0])
            2'd0:    page = 4'd0;
            2'd1:    page = 4'd1;
            2'd2:    page = 4'd3;
            default: page = r[7:4];
        endcase
        return {page, r[11:8]};
    endfunction

    always @(posedge clk) begin : ref_model
        int next_pos;
        next_pos = (m_pos + 1) % FRAME_CYCLES;
        // Status register samples the state before the edge
        case (st_addr[7:4])
            4'd0: m_st <= {v_of(m_pos), m_vint, h_of(m_pos) < 6'(H_VIS),
                           v_of(m_pos) < 5'(V_VIS)};
            4'd1: m_st <= {4'd0, tile_bank};
            4'd3: m_st <= st_addr[0] ? dipsw[15:8] : dipsw[7:0];
            default: m_st <= '0;
        endcase
        m_bank <= tile_bank;
        if (rst) begin
            m_pos       <= 0;
            m_vint      <= 1'b0;
            m_hold      <= 1'b1;
            m_req_valid <= 1'b0;
            m_live      <= 1'b0;
        end else begin
            m_pos       <= next_pos;
            m_vint      <= (next_pos == VINT_LINE * H_TOTAL);
            m_req_valid <= (h_of(next_pos) < 6'(H_VIS)) && (v_of(next_pos) < 5'(V_VIS));
            m_live      <= 1'b1;
            if (v_of(m_pos) == 5'(RST_LINE)) begin
                m_hold <= 1'b0;
            end
        end
    end

    task automatic report_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            report_failure();
        end
    endtask

    // Video, fetch and status outputs against the model
    task automatic check_cycle();
        logic [5:0]  cur_h;
        logic [4:0]  cur_v;
        logic [10:0] raw;
        cur_h = h_of(m_pos);
        cur_v = v_of(m_pos);
        raw   = {cur_v, 3'(cur_h / 8), cur_v[2:0]};
        if (m_live) begin
            check_value("timing.hcnt", timing.hcnt, cur_h);
            check_value("timing.vrender", timing.vrender, cur_v);
            check_value("timing.lhbl", timing.lhbl, cur_h < 6'(H_VIS));
            check_value("timing.lvbl", timing.lvbl, cur_v < 5'(V_VIS));
            check_value("timing.vint", timing.vint, m_vint);
            check_value("char_req.valid", char_req.valid, m_req_valid);
            if (m_req_valid) begin
                check_value("char_req.addr", char_req.addr, {m_bank, raw[8:0]});
            end
            check_value("gfx_ok", gfx_ok, m_req_valid && char_ok);
            check_value("st_dout", st_dout, m_st);
            if (timing.vint) begin
                vint_count++;
            end
            if (m_pos == FRAME_CYCLES - 1) begin
                frames_done++;
                check_value("vint count", vint_count, frames_done);
            end
        end
    endtask

    task automatic next_cycle();
        logic [23:0] r;
        @(negedge clk);
        check_cycle();
        r         = rand_next();
        st_addr   = pick_status_addr(r);
        tile_bank = r[15:12];
        char_ok   = r[16];
    endtask

    task automatic bus_idle();
        bus.stb = 1'b0;
        bus.rnw = 1'b1;
    endtask

    // Palette or work RAM write in one strobe cycle
    task automatic local_write(input logic [2:0] region, input logic [8:0] off,
                               input logic [15:0] data, input logic [1:0] dsn);
        bus.addr = {region, off};
        bus.data = data;
        bus.dsn  = dsn;
        bus.rnw  = 1'b0;
        bus.stb  = 1'b1;
        if (region == MAP_PAL) begin
            pal_m[off[5:0]] = merge_lanes(pal_m[off[5:0]], data, dsn);
        end else begin
            wram_m[off[7:0]] = merge_lanes(wram_m[off[7:0]], data, dsn);
        end
        next_cycle();
        bus_idle();
    endtask

    task automatic local_read(input logic [2:0] region, input logic [8:0] off);
        logic [15:0] exp;
        bus.addr = {region, off};
        bus.dsn  = 2'b00;
        bus.rnw  = 1'b1;
        bus.stb  = 1'b1;
        exp = (region == MAP_PAL) ? pal_m[off[5:0]] : wram_m[off[7:0]];
        next_cycle();
        check_value("cpu_din", cpu_din, exp);
        bus_idle();
    endtask

    // Strobe held until the external RAM answers after delay cycles
    task automatic xram_access(input logic rnw, input logic [8:0] off,
                               input logic [15:0] data, input int delay);
        int  wait_left;
        logic done;
        wait_left = delay;
        done      = 1'b0;
        bus.addr  = {MAP_XRAM, off};
        bus.data  = data;
        bus.dsn   = 2'b00;
        bus.rnw   = rnw;
        bus.stb   = 1'b1;
        xram_data = 16'(rand_next());
        xram_ok   = (wait_left == 0);
        while (!done) begin
            next_cycle();
            check_value("xram_cs", xram_cs, 1'b1);
            check_value("xram_we", xram_we, !rnw);
            check_value("xram_addr", xram_addr, {MAP_XRAM, off});
            check_value("ram_ok", ram_ok, wait_left == 0);
            if (wait_left == 0) begin
                if (rnw) begin
                    check_value("cpu_din", cpu_din, xram_data);
                end
                done = 1'b1;
            end else begin
                wait_left--;
                xram_ok = (wait_left == 0);
            end
        end
        bus_idle();
        xram_ok = 1'b0;
    endtask

    // Main side still held so nothing may reach the memories
    task automatic hold_access();
        logic [23:0] r;
        logic [23:0] d;
        r = rand_next();
        d = rand_next();
        case (r[1:0])
            2'd0:    bus.addr = {MAP_PAL, r[12:4]};
            2'd1:    bus.addr = {MAP_RAM, r[12:4]};
            default: bus.addr = {MAP_XRAM, r[12:4]};
        endcase
        bus.data = d[15:0] | 16'h8001;
        bus.dsn  = 2'b00;
        bus.rnw  = (r[3:2] == 2'd0);
        bus.stb  = 1'b1;
        next_cycle();
        check_value("xram_cs", xram_cs, 1'b0);
        check_value("xram_we", xram_we, 1'b0);
        check_value("ram_ok", ram_ok, 1'b1);
        bus_idle();
    endtask

    initial begin : stimulus
        logic [23:0] r;
        logic [23:0] d;
        int          idx;
        rst       = 1'b1;
        bus       = '0;
        bus.rnw   = 1'b1;
        tile_bank = '0;
        st_addr   = '0;
        char_ok   = 1'b0;
        xram_data = '0;
        xram_ok   = 1'b0;
        r         = rand_next();
        dipsw     = r[23:8];
        for (int i = 0; i < 64; i++) begin
            pal_m[i] = '0;
        end
        repeat (5) next_cycle();
        rst = 1'b0;

        // Accesses during the held reset and then a check of the cleared palette
        repeat (40) hold_access();
        while (m_hold) begin
            next_cycle();
        end
        next_cycle();
        for (int i = 0; i < 64; i++) begin
            r = rand_next();
            local_read(MAP_PAL, {r[2:0], 6'(i)});
        end

        // Palette with random byte lanes
        repeat (96) begin
            r = rand_next();
            d = rand_next();
            if (r[0]) begin
                local_write(MAP_PAL, r[9:1], d[15:0], r[11:10]);
            end else begin
                local_read(MAP_PAL, r[9:1]);
            end
        end

        // External RAM window with random ok delays
        repeat (24) begin
            r = rand_next();
            d = rand_next();
            xram_access(r[0], r[9:1], d[15:0], int'(r[11:10]));
        end

        // Work RAM gets whole words first so every read has a known value
        repeat (16) begin
            r = rand_next();
            d = rand_next();
            wram_known.push_back(r[7:0]);
            local_write(MAP_RAM, r[8:0], d[15:0], 2'b00);
        end
        repeat (64) begin
            r   = rand_next();
            d   = rand_next();
            idx = int'(r[15:8]) % wram_known.size();
            if (r[0]) begin
                local_write(MAP_RAM, {r[1], wram_known[idx]}, d[15:0], r[3:2]);
            end else begin
                local_read(MAP_RAM, {r[1], wram_known[idx]});
            end
        end

        // Timing, fetch and status keep running until enough frames are seen
        while (frames_done < RUN_FRAMES) begin
            next_cycle();
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tiny16.f
hw/tiny16_pkg.sv
hw/tiny16_decode.sv
hw/tiny16_video.sv
hw/tiny16_mem.sv
hw/tiny16_game.sv
tests/tiny16_tb.sv
